//--- sources.f
source/ecc_pkg.sv
source/ecc_reg_pkg.sv
source/ecc_stage_if.sv
source/ecc_regs.sv
source/ecc_encoder.sv
source/ecc_syndrome.sv
source/ecc_corrector.sv
source/ecc_top.sv
dv/tb_ecc_top.sv

//--- dv/ecc_stimulus.txt
# op arg aux cls in hex; op W mode write, E encode, D decode, R reg read, C clear, F random flips
# E aux codeword; D aux data_out, cls class; R arg addr, aux rdata; F aux width, cls flip count
R 0 0 0
E b b1 0
E f ff 0
D b1 b1 0
D 55 55 0
D b0 b1 1
D 31 b1 1
D b7 0 2
F b1 8 1
W 1 0 0
D aaa5 aaa5 0
R 0 1 0
E 7ff ffff 0
E 555 aaa5 0
D 2aa5 aaa5 1
F ffff 10 2
W 2 0 0
E 1 63 0
E 3ffffff ffffffff 0
E 2000000 8000001f 0
D 8000001f 8000001f 0
D 1f 8000001f 1
D 60 0 2
F ffffffff 20 1
F 63 20 2
W 3 0 0
E 1234567 1234567 0
D deadbeef deadbeef 0
R 0 3 0
R 1 6 0
R 2 4 0
C 0 0 0
R 1 0 0
R 2 0 0

//--- dv/tb_ecc_top.sv
`timescale 1ns/10ps

module tb_ecc_top import ecc_pkg::*, ecc_reg_pkg::*; ();

    logic                      clk;
    logic                      rst;
    logic                      wr_en;
    logic                      rd_en;
    logic [reg_addr_width-1:0] addr;
    logic [reg_data_width-1:0] wdata;
    logic [reg_data_width-1:0] rdata;
    logic                      enc_valid;
    logic [max_info_width-1:0] enc_data;
    logic                      enc_out_valid;
    logic [max_cw_width-1:0]   codeword;
    logic                      dec_valid;
    logic [max_cw_width-1:0]   dec_word;
    logic                      dec_out_valid;
    logic [max_cw_width-1:0]   data_out;
    err_class_e                err_class;

    // stimulus lines as read from the file
    logic [7:0]  op_q[$];
    logic [31:0] arg_q[$];
    logic [31:0] aux_q[$];
    logic [31:0] cls_q[$];

    // expected results in flight, due is the negedge count
    logic [max_cw_width-1:0] enc_exp_q[$];
    int                      enc_due_q[$];
    logic [max_cw_width-1:0] dec_exp_q[$];
    err_class_e              dec_cls_q[$];
    logic                    dec_chk_q[$];
    int                      dec_due_q[$];

    int     n_lines;
    int     cyc;
    integer seed;

    ecc_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("=== FAIL ===");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_codeword(input logic [max_cw_width-1:0] got,
                                  input logic [max_cw_width-1:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_class(input err_class_e got, input err_class_e exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: error class got %0d expected %0d", $time, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_reg(input logic [reg_data_width-1:0] got,
                             input logic [reg_data_width-1:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          ch;
        logic [31:0] arg;
        logic [31:0] aux;
        logic [31:0] cls;
        fd = $fopen("dv/ecc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open dv/ecc_stimulus.txt");
            end_in_failure();
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != "\n" && ch != -1)
                    ch = $fgetc(fd); // rest of a comment line
            end else if (ch >= "A" && ch <= "Z") begin
                if ($fscanf(fd, "%h %h %h", arg, aux, cls) != 3) begin
                    $display("ERROR: stimulus line %0d is incomplete", op_q.size() + 1);
                    end_in_failure();
                end
                op_q.push_back(8'(ch));
                arg_q.push_back(arg);
                aux_q.push_back(aux);
                cls_q.push_back(cls);
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        n_lines = op_q.size();
    endtask

    task automatic idle_inputs();
        wr_en     <= 1'b0;
        rd_en     <= 1'b0;
        enc_valid <= 1'b0;
        dec_valid <= 1'b0;
    endtask

    // wait until every word in flight has been checked
    task automatic drain_pipes();
        while (enc_exp_q.size() != 0 || dec_exp_q.size() != 0) begin
            @(posedge clk);
            idle_inputs();
        end
    endtask

    task automatic expect_decode(input logic [max_cw_width-1:0] data, input err_class_e cls,
                                 input logic chk);
        dec_exp_q.push_back(data);
        dec_cls_q.push_back(cls);
        dec_chk_q.push_back(chk);
        dec_due_q.push_back(cyc + 3); // two cycles after the sampling edge
    endtask

    always @(negedge clk) begin : watch_outputs
        logic [max_cw_width-1:0] exp_word;
        err_class_e              exp_cls;
        logic                    chk;
        cyc = cyc + 1;
        if (enc_out_valid || (enc_due_q.size() != 0 && enc_due_q[0] == cyc)) begin
            if (!enc_out_valid || enc_due_q.size() == 0 || enc_due_q[0] != cyc) begin
                $display("ERROR: encoder output missing or off its latency at %0t", $time);
                end_in_failure();
            end
            enc_due_q.delete(0);
            exp_word = enc_exp_q.pop_front();
            check_codeword(codeword, exp_word, "encoder codeword");
        end
        if (dec_out_valid || (dec_due_q.size() != 0 && dec_due_q[0] == cyc)) begin
            if (!dec_out_valid || dec_due_q.size() == 0 || dec_due_q[0] != cyc) begin
                $display("ERROR: decoder output missing or off its latency at %0t", $time);
                end_in_failure();
            end
            dec_due_q.delete(0);
            exp_word = dec_exp_q.pop_front();
            exp_cls  = dec_cls_q.pop_front();
            chk      = dec_chk_q.pop_front();
            check_class(err_class, exp_cls);
            if (chk)
                check_codeword(data_out, exp_word, "decoder data_out");
        end
    end

    initial begin
        int          pos1;
        int          pos2;
        logic [31:0] word;
        logic [7:0]  op;
        seed      = 32'hfa51_d522;
        cyc       = 0;
        rst       = 1'b0;
        wr_en     = 1'b0;
        rd_en     = 1'b0;
        addr      = '0;
        wdata     = '0;
        enc_valid = 1'b0;
        enc_data  = '0;
        dec_valid = 1'b0;
        dec_word  = '0;
        load_stimulus();
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            op = op_q[i];
            if (op == "R" || op == "C")
                drain_pipes(); // counters settle first
            @(posedge clk);
            idle_inputs();
            case (op)
                "W": begin
                    wr_en <= 1'b1;
                    addr  <= addr_mode;
                    wdata <= arg_q[i][reg_data_width-1:0];
                end
                "C": begin
                    wr_en <= 1'b1;
                    addr  <= addr_clear;
                    wdata <= '0;
                end
                "E": begin
                    enc_valid <= 1'b1;
                    enc_data  <= arg_q[i][max_info_width-1:0];
                    enc_exp_q.push_back(aux_q[i]);
                    enc_due_q.push_back(cyc + 2);
                end
                "D": begin
                    dec_valid <= 1'b1;
                    dec_word  <= arg_q[i];
                    expect_decode(aux_q[i], err_class_e'(cls_q[i][1:0]), cls_q[i] != 2);
                end
                "F": begin
                    pos1 = $unsigned($random(seed)) % aux_q[i];
                    word = arg_q[i] ^ (32'd1 << pos1);
                    pos2 = pos1;
                    if (cls_q[i] == 2) begin
                        while (pos2 == pos1)
                            pos2 = $unsigned($random(seed)) % aux_q[i];
                        word = word ^ (32'd1 << pos2);
                    end
                    dec_valid <= 1'b1;
                    dec_word  <= word;
                    expect_decode(arg_q[i], (cls_q[i] == 2) ? err_double : err_single,
                                  cls_q[i] != 2);
                end
                "R": begin
                    rd_en <= 1'b1;
                    addr  <= arg_q[i][reg_addr_width-1:0];
                    @(negedge clk); // rdata is combinational
                    check_reg(rdata, aux_q[i][reg_data_width-1:0], "register read");
                end
                default: begin
                    $display("ERROR: unknown operation on stimulus line %0d", i + 1);
                    end_in_failure();
                end
            endcase
        end
        @(posedge clk);
        idle_inputs();
        repeat (4) @(posedge clk); // longer than the decoder latency
        if (enc_exp_q.size() == 0 && dec_exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("ERROR: expected outputs never arrived");
            end_in_failure();
        end
    end

    // run length bound from the number of stimulus lines
    initial begin
        #1;
        repeat (20 * n_lines + 100) @(posedge clk);
        $display("ERROR: timeout, the run did not finish in %0d cycles", 20 * n_lines + 100);
        end_in_failure();
    end

endmodule

//--- source/ecc_top.sv
`timescale 1ns/10ps

module ecc_top import ecc_pkg::*, ecc_reg_pkg::*; #(
    parameter int cnt_width = ecc_reg_pkg::cnt_width
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  logic [reg_addr_width-1:0] addr,
    input  logic [reg_data_width-1:0] wdata,
    output logic [reg_data_width-1:0] rdata,
    input  logic                      enc_valid,
    input  logic [max_info_width-1:0] enc_data,
    output logic                      enc_out_valid,
    output logic [max_cw_width-1:0]   codeword,
    input  logic                      dec_valid,
    input  logic [max_cw_width-1:0]   dec_word,
    output logic                      dec_out_valid,
    output logic [max_cw_width-1:0]   data_out,
    output err_class_e                err_class
);

    ecc_mode_e cfg_mode;
    logic      corr_pulse;
    logic      uncorr_pulse;

    ecc_stage_if u_stage ();  // syndrome stage to correct stage

    ecc_regs #(
        .cnt_width(cnt_width)
    ) u_regs (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .addr         (addr),
        .wdata        (wdata),
        .corr_pulse   (corr_pulse),
        .uncorr_pulse (uncorr_pulse),
        .rdata        (rdata),
        .cfg_mode     (cfg_mode)
    );

    ecc_encoder u_encoder (
        .clk           (clk),
        .rst           (rst),
        .cfg_mode      (cfg_mode),
        .enc_valid     (enc_valid),
        .enc_data      (enc_data),
        .enc_out_valid (enc_out_valid),
        .codeword      (codeword)
    );

    ecc_syndrome u_syndrome (
        .clk       (clk),
        .rst       (rst),
        .cfg_mode  (cfg_mode),
        .dec_valid (dec_valid),
        .dec_word  (dec_word),
        .stage     (u_stage)
    );

    ecc_corrector u_corrector (
        .clk           (clk),
        .rst           (rst),
        .stage         (u_stage),
        .dec_out_valid (dec_out_valid),
        .data_out      (data_out),
        .err_class     (err_class),
        .corr_pulse    (corr_pulse),
        .uncorr_pulse  (uncorr_pulse)
    );

endmodule

//--- source/ecc_corrector.sv
`timescale 1ns/10ps

module ecc_corrector import ecc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    ecc_stage_if.dst                stage,
    output logic                    dec_out_valid,
    output logic [max_cw_width-1:0] data_out,
    output err_class_e              err_class,
    output logic                    corr_pulse,
    output logic                    uncorr_pulse
);

    logic [max_par_width-1:0][max_cw_width-1:0] h_rows;
    logic [max_cw_width-1:0][max_par_width-1:0] h_cols;
    logic [max_cw_width-1:0]                    corr_vec;
    logic                                       col_hit;
    err_class_e                                 class_next;

    always_comb begin
        for (int r = 0; r < max_par_width; r++) begin
            h_rows[r] = h_row(stage.mode, r);
        end
        for (int c = 0; c < max_cw_width; c++) begin
            for (int r = 0; r < max_par_width; r++) begin
                h_cols[c][r] = h_rows[r][c];
            end
        end
    end

    // one bit per column whose pattern equals the syndrome
    always_comb begin
        for (int c = 0; c < max_cw_width; c++) begin
            corr_vec[c] = (c < cw_width(stage.mode)) &&
                          (stage.syndrome != '0) &&
                          (h_cols[c] == stage.syndrome);
        end
    end

    assign col_hit = |corr_vec;

    // priority order matters here
    always_comb begin
        if (stage.syndrome == '0)
            class_next = err_none;
        else if (col_hit)
            class_next = err_single;
        else
            class_next = err_double;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dec_out_valid <= 1'b0;
            corr_pulse    <= 1'b0;
            uncorr_pulse  <= 1'b0;
            data_out      <= '0;
            err_class     <= err_none;
        end else begin
            dec_out_valid <= stage.valid;
            corr_pulse    <= stage.valid && (class_next == err_single);
            uncorr_pulse  <= stage.valid && (class_next == err_double);
            if (stage.valid) begin
                data_out  <= stage.word ^ corr_vec; // flip the bad bit
                err_class <= class_next;
            end
        end
    end

endmodule

//--- source/ecc_syndrome.sv
`timescale 1ns/10ps

module ecc_syndrome import ecc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  ecc_mode_e               cfg_mode,
    input  logic                    dec_valid,
    input  logic [max_cw_width-1:0] dec_word,
    ecc_stage_if.src                stage
);

    logic [max_par_width-1:0] syn_next;

    // one parity check per matrix row
    // bypass rows are all zero so the syndrome stays zero there
    always_comb begin
        for (int r = 0; r < max_par_width; r++) begin
            syn_next[r] = ^(dec_word & h_row(cfg_mode, r));
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            stage.valid <= 1'b0;
        else
            stage.valid <= dec_valid;
    end

    // word, syndrome and mode move together
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            stage.word     <= dec_word;
            stage.syndrome <= syn_next;
            stage.mode     <= cfg_mode;
        end
    end

endmodule

//--- source/ecc_encoder.sv
`timescale 1ns/10ps

module ecc_encoder import ecc_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  ecc_mode_e                 cfg_mode,
    input  logic                      enc_valid,
    input  logic [max_info_width-1:0] enc_data,
    output logic                      enc_out_valid,
    output logic [max_cw_width-1:0]   codeword
);

    logic [max_cw_width-1:0] cw_next;
    int                      info_w;
    int                      par_w;

    always_comb begin
        info_w  = info_width(cfg_mode);
        par_w   = par_width(cfg_mode);
        cw_next = '0;
        if (cfg_mode == mode_bypass) begin
            cw_next = max_cw_width'(enc_data); // data goes out as is
        end else begin
            // info bits sit above the parity positions
            for (int i = 0; i < max_info_width; i++) begin
                if (i < info_w)
                    cw_next[i + par_w] = enc_data[i];
            end
            // hamming rows only cover their own parity position,
            // so the still-zero parity bits drop out of the xor
            for (int r = 0; r < max_par_width - 1; r++) begin
                if (r < par_w - 1)
                    cw_next[r] = ^(cw_next & h_row(cfg_mode, r));
            end
            // overall parity last, over everything else
            cw_next[par_w - 1] = ^cw_next;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            enc_out_valid <= 1'b0;
        else
            enc_out_valid <= enc_valid;
    end

    always_ff @(posedge clk) begin
        if (enc_valid)
            codeword <= cw_next;
    end

endmodule

//--- source/ecc_regs.sv
`timescale 1ns/10ps

module ecc_regs import ecc_pkg::*, ecc_reg_pkg::*; #(
    parameter int cnt_width = ecc_reg_pkg::cnt_width
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  logic [reg_addr_width-1:0] addr,
    input  logic [reg_data_width-1:0] wdata,
    input  logic                      corr_pulse,
    input  logic                      uncorr_pulse,
    output logic [reg_data_width-1:0] rdata,
    output ecc_mode_e                 cfg_mode
);

    logic [cnt_width-1:0] corr_cnt;
    logic [cnt_width-1:0] uncorr_cnt;
    logic                 clear_hit;

    assign clear_hit = wr_en && (addr == addr_clear);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cfg_mode <= mode_8_4;
        end else if (wr_en && (addr == addr_mode)) begin
            cfg_mode <= ecc_mode_e'(wdata[mode_field_width-1:0]);
        end
    end

    // clear wins over a pulse in the same cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            corr_cnt   <= '0;
            uncorr_cnt <= '0;
        end else if (clear_hit) begin
            corr_cnt   <= '0;
            uncorr_cnt <= '0;
        end else begin
            if (corr_pulse && (corr_cnt != '1))
                corr_cnt <= corr_cnt + 1'b1;     // hold at max
            if (uncorr_pulse && (uncorr_cnt != '1))
                uncorr_cnt <= uncorr_cnt + 1'b1;
        end
    end

    // read mux, same cycle as rd_en
    always_comb begin
        rdata = '0;
        if (rd_en) begin
            case (addr)
                addr_mode:       rdata = reg_data_width'(cfg_mode);
                addr_corr_cnt:   rdata = reg_data_width'(corr_cnt);
                addr_uncorr_cnt: rdata = reg_data_width'(uncorr_cnt);
                default:         rdata = '0; // clear reads back as zero
            endcase
        end
    end

endmodule

//--- source/ecc_stage_if.sv
`timescale 1ns/10ps

interface ecc_stage_if import ecc_pkg::*; ();

    logic                     valid;    // one cycle strobe
    logic [max_cw_width-1:0]  word;     // received word, one cycle late
    logic [max_par_width-1:0] syndrome;
    ecc_mode_e                mode;     // mode the syndrome was taken in

    modport src (
        output valid,
        output word,
        output syndrome,
        output mode
    );

    modport dst (
        input valid,
        input word,
        input syndrome,
        input mode
    );

endinterface

//--- source/ecc_reg_pkg.sv
package ecc_reg_pkg;

    localparam int reg_addr_width = 2;
    localparam int reg_data_width = 16;

    // register map
    localparam logic [reg_addr_width-1:0] addr_mode       = 2'd0;
    localparam logic [reg_addr_width-1:0] addr_corr_cnt   = 2'd1;
    localparam logic [reg_addr_width-1:0] addr_uncorr_cnt = 2'd2;
    localparam logic [reg_addr_width-1:0] addr_clear      = 2'd3;

    // mode field in the low bits of wdata / rdata
    localparam int mode_field_width = 2;

    // default error counter width, counters saturate
    localparam int cnt_width = 16;

endpackage

//--- source/ecc_pkg.sv
package ecc_pkg;

    localparam int max_cw_width   = 32;
    localparam int max_info_width = 26;
    localparam int max_par_width  = max_cw_width - max_info_width;

    typedef enum logic [1:0] {
        mode_8_4    = 2'd0,
        mode_16_11  = 2'd1,
        mode_32_26  = 2'd2,
        mode_bypass = 2'd3
    } ecc_mode_e;

    // encoding 3 is never produced
    typedef enum logic [1:0] {
        err_none   = 2'd0,
        err_single = 2'd1,
        err_double = 2'd2
    } err_class_e;

    // row r sits in bits [r*cols +: cols], top row is overall parity
    localparam logic [max_par_width-1:0][7:0] h_matrix_8 = 48'h0000_FFE4_D2B1;
    localparam logic [max_par_width-1:0][15:0] h_matrix_16 =
        96'h0000_FFFF_FE08_F1C4_CDA2_AB61;
    localparam logic [max_par_width-1:0][31:0] h_matrix_32 =
        192'hFFFF_FFFF_FFFE_0010_FF01_FC08_F0F1_E384_CCCD_9B42_AAAB_56C1;

    function automatic int info_width(ecc_mode_e mode);
        case (mode)
            mode_8_4:   return 4;
            mode_16_11: return 11;
            default:    return max_info_width; // 32/26 and bypass
        endcase
    endfunction

    function automatic int par_width(ecc_mode_e mode);
        case (mode)
            mode_8_4:    return 4;
            mode_16_11:  return 5;
            mode_32_26:  return 6;
            default:     return 0;
        endcase
    endfunction

    function automatic int cw_width(ecc_mode_e mode);
        return (mode == mode_bypass) ? max_cw_width : info_width(mode) + par_width(mode);
    endfunction

    // one matrix row, zero padded to the full codeword width
    function automatic logic [max_cw_width-1:0] h_row(ecc_mode_e mode, int r);
        case (mode)
            mode_8_4:   return max_cw_width'(h_matrix_8[r]);
            mode_16_11: return max_cw_width'(h_matrix_16[r]);
            mode_32_26: return h_matrix_32[r];
            default:    return '0; // bypass covers nothing
        endcase
    endfunction

endpackage
